//--- Bender.yml
package:
  name: lane_rx

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/lane_rx_pkg.sv
      - verilog/gearbox_32_33.sv
      - verilog/block_lock.sv
      - verilog/lane_arbiter.sv
      - verilog/lane_rx_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/lane_rx_properties.sv
      - tests/lane_rx_tb.sv

//--- lane_rx_top.f
+incdir+verilog
verilog/lane_rx_pkg.sv
verilog/gearbox_32_33.sv
verilog/block_lock.sv
verilog/lane_arbiter.sv
verilog/lane_rx_top.sv
tests/lane_rx_properties.sv
tests/lane_rx_tb.sv

//--- tests/lane_rx_properties.sv
`default_nettype none
`timescale 1ns/10ps
`include "lane_rx_macros.svh"

module lane_rx_properties (
	input logic clk,
	input logic arst,
	input logic out_valid,
	input logic credit_return,
	input logic slip,
	input logic locked,
	input logic blk_valid
);

	// blocks seen while the lane is hunting, cleared while it is locked
	logic [15:0] hunt_blocks;
	// words sent to the consumer whose credit has not come back yet
	logic [7:0] in_flight;

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			hunt_blocks <= '0;
		end else if (locked) begin
			hunt_blocks <= '0;
		end else if (blk_valid && hunt_blocks != 16'hffff) begin
			hunt_blocks <= hunt_blocks + 16'd1;
		end
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			in_flight <= '0;
		end else if (out_valid && !credit_return) begin
			in_flight <= in_flight + 8'd1;
		end else if (credit_return && !out_valid) begin
			in_flight <= in_flight - 8'd1;
		end
	end

	// a word may only leave while fewer than OUT_CREDITS words wait for their credit
	credit_held: assert property (@(posedge clk) disable iff (arst)
		out_valid |-> in_flight < 8'(`OUT_CREDITS))
		else $error("out_valid with %0d words still waiting for credit", in_flight);

	// the gearbox must not be slipped once the block boundary is found
	no_slip_locked: assert property (@(posedge clk) disable iff (arst)
		!(slip && locked))
		else $error("slip requested while locked");

	// lock needs LOCK_GOOD full align periods of hunting first
	lock_not_early: assert property (@(posedge clk) disable iff (arst)
		$rose(locked) |-> hunt_blocks >= 16'(`LOCK_GOOD * `ALIGN_PERIOD))
		else $error("lock declared after only %0d blocks", hunt_blocks);

endmodule

bind lane_arbiter lane_rx_properties arb_props_i (
	.clk           (clk),
	.arst          (arst),
	.out_valid     (out_valid),
	.credit_return (credit_return),
	.slip          (1'b0),
	.locked        (1'b0),
	.blk_valid     (1'b0)
);

bind block_lock lane_rx_properties lock_props_i (
	.clk           (clk),
	.arst          (arst),
	.out_valid     (1'b0),
	.credit_return (1'b0),
	.slip          (slip),
	.locked        (locked),
	.blk_valid     (blk_valid)
);

`default_nettype wire

//--- tests/lane_rx_tb.sv
`default_nettype none
`timescale 1ns/10ps
`include "lane_rx_macros.svh"

module lane_rx_tb import lane_rx_pkg::*; ();

	logic clk;
	logic arst;
	logic [1:0][31:0] raw_word;
	logic [1:0] raw_valid;
	logic credit_return;
	rx_word_t out_word;
	logic out_valid;
	logic [1:0] locked;
	logic [1:0] overflow;

	integer seed = 32'h5e072088;

	// transmitter state per lane, bits not yet sent sit at the bottom of sbuf
	logic [127:0] sbuf [2];
	int nbits [2];
	int blk_pos [2];
	int drop_bits [2];
	int drop_seq [2];
	int drop_done [2];
	logic tx_run;

	// blocks the receiver should forward, align blocks left out
	block_t exp_q0 [$];
	block_t exp_q1 [$];
	logic resync [2];
	logic relock [2];
	int words_ok [2];
	int ctl_seen;
	logic lock_seen0;

	// consumer side bookkeeping
	int rcvd;
	int returned;
	logic stall;
	int stall_words;

	lane_rx_top dut_i (
		.clk           (clk),
		.arst          (arst),
		.raw_word      (raw_word),
		.raw_valid     (raw_valid),
		.credit_return (credit_return),
		.out_word      (out_word),
		.out_valid     (out_valid),
		.locked        (locked),
		.overflow      (overflow)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// next block of a lane's stream, with an align block opening every period
	function automatic block_t make_block(input int l);
		block_t b;
		logic [7:0] t;
		logic [15:0] v;
		int r;
		v = 16'($random(seed));
		r = $random(seed) & 7;
		if (blk_pos[l] % `ALIGN_PERIOD == 0) t = CTL_ALIGN;
		else if (r == 0) t = CTL_IDLE;
		else if (r == 1) t = CTL_MARK;
		else t = 8'h00;
		if (t == 8'h00) begin
			b.data.payload = 32'($random(seed));
			b.data.kind = 1'b1;
		end else begin
			b.ctl.kind = 1'b0;
			b.ctl.ctype = t;
			b.ctl.value = v;
			b.ctl.check = t ^ v[15:8] ^ v[7:0];
		end
		blk_pos[l]++;
		if (t != CTL_ALIGN) begin
			if (l == 0) exp_q0.push_back(b);
			else exp_q1.push_back(b);
		end
		return b;
	endfunction

	// serialize blocks bit 0 first until at least need bits are waiting
	task automatic fill_bits(input int l, input int need);
		block_t b;
		while (nbits[l] < need) begin
			b = make_block(l);
			sbuf[l] = sbuf[l] | (128'(b) << nbits[l]);
			nbits[l] += 33;
		end
	endtask

	// transmitter, a dropped bit count shifts the stream against the receiver
	always @(posedge clk) begin
		if (arst) begin
			raw_valid <= 2'b00;
		end else if (tx_run) begin
			for (int l = 0; l < 2; l++) begin
				if (drop_seq[l] != drop_done[l]) begin
					fill_bits(l, drop_bits[l]);
					sbuf[l] = sbuf[l] >> drop_bits[l];
					nbits[l] -= drop_bits[l];
					drop_done[l] = drop_seq[l];
				end
				if (($random(seed) & 15) < 7) begin
					fill_bits(l, 32);
					raw_word[l] <= sbuf[l][31:0];
					sbuf[l] = sbuf[l] >> 32;
					nbits[l] -= 32;
					raw_valid[l] <= 1'b1;
				end else begin
					raw_valid[l] <= 1'b0;
				end
			end
		end
	end

	// consumer hands credits back after random delays unless stalled
	always @(posedge clk) begin
		if (arst) begin
			credit_return <= 1'b0;
		end else begin
			if (out_valid) begin
				rcvd++;
				if (stall) stall_words++;
			end
			assert (stall_words <= `OUT_CREDITS) else begin
				$display("TEST FAILED");
				$fatal(1, "Fail stall_words: got %h limit %h", stall_words, `OUT_CREDITS);
			end
			if (!stall && rcvd > returned && ($random(seed) & 15) != 0) begin
				credit_return <= 1'b1;
				returned++;
			end else begin
				credit_return <= 1'b0;
			end
		end
	end

	// compare a forwarded block against the head of its lane's queue
	task automatic check_word(input int l, input block_t got);
		block_t head;
		int n;
		n = (l == 0) ? exp_q0.size() : exp_q1.size();
		if (resync[l]) begin
			// entries sent before lock are skipped up to the first match
			while (n > 0 && ((l == 0) ? exp_q0[0] : exp_q1[0]) != got) begin
				if (l == 0) void'(exp_q0.pop_front());
				else void'(exp_q1.pop_front());
				n--;
			end
		end
		assert (n > 0) else begin
			$display("TEST FAILED");
			$fatal(1, "lane %0d forwarded a block that was never sent: %h", l, got);
		end
		head = (l == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
		assert (got == head) else begin
			$display("TEST FAILED");
			$fatal(1, "Fail out_word.blk lane %0d: got %h expected %h", l, got, head);
		end
		if (!got.ctl.kind) ctl_seen++;
		resync[l] = 1'b0;
		words_ok[l]++;
	endtask

	// scoreboard, lane 1 words during a forced realign are not compared
	always @(posedge clk) begin
		if (!arst) begin
			if (lock_seen0) begin
				assert (locked[0]) else begin
					$display("TEST FAILED");
					$fatal(1, "Fail locked[0]: got %h expected %h", locked[0], 1'b1);
				end
			end
			if (locked[0]) lock_seen0 = 1'b1;
			if (out_valid) begin
				// no align block may leave and every control block keeps a good check byte
				if (!out_word.blk.ctl.kind) begin
					assert (out_word.blk.ctl.ctype != CTL_ALIGN &&
						out_word.blk.ctl.check == (out_word.blk.ctl.ctype ^
						out_word.blk.ctl.value[15:8] ^ out_word.blk.ctl.value[7:0]))
					else begin
						$display("TEST FAILED");
						$fatal(1, "Fail out_word.blk control: got %h", out_word.blk);
					end
				end
				if (relock[out_word.lane]) resync[out_word.lane] = 1'b1;
				else check_word(int'(out_word.lane), out_word.blk);
			end
		end
	end

	task automatic wait_lock_level(input int l, input logic level, input int limit);
		int i;
		i = 0;
		while (locked[l] !== level && i < limit) begin
			@(posedge clk);
			i++;
		end
		if (locked[l] !== level) begin
			$display("TEST FAILED");
			$fatal(1, "lane %0d did not change its lock state to %0d in time", l, level);
		end
	endtask

	task automatic wait_words(input int l, input int count, input int limit);
		int i;
		int target;
		@(negedge clk);
		i = 0;
		target = words_ok[l] + count;
		while (words_ok[l] < target && i < limit) begin
			@(negedge clk);
			i++;
		end
		if (words_ok[l] < target) begin
			$display("TEST FAILED");
			$fatal(1, "lane %0d did not forward enough matching blocks in time", l);
		end
	endtask

	// realign lane 1 by dropping bits, then wait for unlock, relock and good data
	task automatic shift_lane1(input int bits);
		relock[1] <= 1'b1;
		drop_bits[1] <= bits;
		drop_seq[1] <= drop_seq[1] + 1;
		wait_lock_level(1, 1'b0, 2000);
		wait_lock_level(1, 1'b1, 30000);
		relock[1] <= 1'b0;
		wait_words(1, 40, 3000);
	endtask

	initial begin
		arst = 1'b1;
		raw_word = '0;
		raw_valid = 2'b00;
		credit_return = 1'b0;
		tx_run = 1'b0;
		stall = 1'b0;
		stall_words = 0;
		rcvd = 0;
		returned = 0;
		ctl_seen = 0;
		lock_seen0 = 1'b0;
		for (int l = 0; l < 2; l++) begin
			sbuf[l] = '0;
			nbits[l] = 0;
			blk_pos[l] = 0;
			resync[l] = 1'b1;
			relock[l] = 1'b0;
			words_ok[l] = 0;
			// each lane starts at its own random bit offset
			drop_bits[l] = ($random(seed) & 32'h7fff) % 33;
			drop_seq[l] = 1;
			drop_done[l] = 0;
		end
		repeat (4) @(posedge clk);
		arst <= 1'b0;
		tx_run <= 1'b1;
		wait_lock_level(0, 1'b1, 30000);
		wait_lock_level(1, 1'b1, 30000);
		wait_words(0, 60, 3000);
		wait_words(1, 60, 3000);
		// hold credits back for a short stretch that the FIFOs can absorb
		stall <= 1'b1;
		repeat (8) @(posedge clk);
		stall <= 1'b0;
		wait_words(0, 30, 2000);
		wait_words(1, 30, 2000);
		shift_lane1(1);
		// a second offset, anywhere from 2 to 31 bits
		shift_lane1(2 + (($random(seed) & 32'h7fff) % 30));
		wait_words(0, 30, 2000);
		if (overflow != 2'b00) begin
			$display("TEST FAILED");
			$fatal(1, "Fail overflow: got %h expected %h", overflow, 2'b00);
		end else if (ctl_seen == 0) begin
			$display("TEST FAILED");
			$fatal(1, "no idle or mark block reached the output");
		end else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- verilog/block_lock.sv
`default_nettype none
`timescale 1ns/10ps
`include "lane_rx_macros.svh"

module block_lock import lane_rx_pkg::*; (
	input logic clk,
	input logic arst,
	input logic raw_valid,
	input block_t blk,
	input logic blk_valid,
	output logic slip,
	output logic locked,
	output block_t fwd_blk,
	output logic fwd_valid
);

	localparam logic [7:0] LAST_SLOT = `ALIGN_PERIOD - 8'd1;
	localparam int GOOD_W = $clog2(`LOCK_GOOD + 1);
	localparam int BAD_W = $clog2(`LOCK_BAD + 1);
	localparam logic [GOOD_W-1:0] GOOD_LAST = GOOD_W'(`LOCK_GOOD - 1);
	localparam logic [BAD_W-1:0] BAD_LAST = BAD_W'(`LOCK_BAD - 1);

	// blocks seen since the last align block or the last slip
	logic [7:0] blk_cnt;
	// an align block has been seen since the last slip or unlock
	logic synced;
	logic [GOOD_W-1:0] good_cnt;
	logic [BAD_W-1:0] bad_cnt;

	logic ctl_ok;
	logic is_align;
	logic can_fwd;
	logic at_boundary;

	always_comb begin
		ctl_ok = !blk.ctl.kind && (blk.ctl.check == ctl_check(blk.ctl.ctype, blk.ctl.value));
		is_align = ctl_ok && (blk.ctl.ctype == CTL_ALIGN);
		// data always passes, control only when intact and not a marker
		can_fwd = blk.data.kind || (ctl_ok && !is_align);
		at_boundary = (blk_cnt == LAST_SLOT);
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			blk_cnt <= '0;
			synced <= 1'b0;
			good_cnt <= '0;
			bad_cnt <= '0;
			locked <= 1'b0;
			slip <= 1'b0;
			fwd_valid <= 1'b0;
		end else begin
			fwd_valid <= blk_valid && locked && can_fwd;
			// the gearbox takes the slip together with the next raw word
			if (slip && raw_valid) begin
				slip <= 1'b0;
			end
			if (blk_valid && !locked) begin
				if (is_align) begin
					blk_cnt <= '0;
					synced <= 1'b1;
					if (synced && at_boundary && good_cnt == GOOD_LAST) begin
						locked <= 1'b1;
						good_cnt <= '0;
						bad_cnt <= '0;
					end else if (synced && at_boundary) begin
						good_cnt <= good_cnt + 1'b1;
					end else begin
						// an align off the expected slot becomes the new reference
						good_cnt <= '0;
					end
				end else if (at_boundary) begin
					// a whole period without an align means the offset is wrong
					slip <= 1'b1;
					blk_cnt <= '0;
					synced <= 1'b0;
					good_cnt <= '0;
				end else begin
					blk_cnt <= blk_cnt + 8'd1;
				end
			end else if (blk_valid) begin
				if (at_boundary) begin
					blk_cnt <= '0;
					if (is_align) begin
						bad_cnt <= '0;
					end else if (bad_cnt == BAD_LAST) begin
						// too many misses in a row so go back to hunting
						locked <= 1'b0;
						synced <= 1'b0;
						bad_cnt <= '0;
					end else begin
						bad_cnt <= bad_cnt + 1'b1;
					end
				end else begin
					blk_cnt <= blk_cnt + 8'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (blk_valid) begin
			fwd_blk <= blk;
		end
	end

endmodule

`default_nettype wire

//--- verilog/gearbox_32_33.sv
`default_nettype none
`timescale 1ns/10ps

module gearbox_32_33 import lane_rx_pkg::*; (
	input logic clk,
	input logic arst,
	input logic [31:0] din,
	input logic din_valid,
	input logic din_slip,
	output block_t dout,
	output logic dout_valid
);

	// bits waiting to become part of the next block, oldest at bit 0
	logic [31:0] held;
	// how many bits of held are valid, anywhere from 0 to 32
	logic [5:0] fill;

	logic [31:0] word_in;
	logic [5:0] word_bits;
	logic [6:0] total;
	logic [63:0] merged;
	logic emit;

	always_comb begin
		// a slip throws away bit 0 of this word so the block boundary moves by one bit
		word_in = din_slip ? {1'b0, din[31:1]} : din;
		word_bits = din_slip ? 6'd31 : 6'd32;
		total = {1'b0, fill} + {1'b0, word_bits};
		// the new word lands right above the bits already held
		merged = {32'd0, held} | ({32'd0, word_in} << fill);
		// a block leaves whenever 33 bits are on hand
		emit = din_valid && (total >= 7'd33);
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			held <= '0;
			fill <= '0;
			dout_valid <= 1'b0;
		end else begin
			dout_valid <= emit;
			if (emit) begin
				// fill drops by one per plain word and by two on a slip, modulo 33
				held <= {1'b0, merged[63:33]};
				fill <= 6'(total - 7'd33);
			end else if (din_valid) begin
				// with fill at 0, or at 1 on a slip, this word only tops up the store
				held <= merged[31:0];
				fill <= total[5:0];
			end
		end
	end

	// the finished block is the lowest 33 bits of the merged stream
	always_ff @(posedge clk) begin
		if (emit) begin
			dout <= block_t'(merged[32:0]);
		end
	end

endmodule

`default_nettype wire

//--- verilog/lane_arbiter.sv
`default_nettype none
`timescale 1ns/10ps
`include "lane_rx_macros.svh"

module lane_arbiter import lane_rx_pkg::*; (
	input logic clk,
	input logic arst,
	input block_t [`NUM_LANES-1:0] in_blk,
	input logic [`NUM_LANES-1:0] in_valid,
	input logic credit_return,
	output rx_word_t out_word,
	output logic out_valid,
	output wire [`NUM_LANES-1:0] overflow
);

	localparam int LANE_W = $clog2(`NUM_LANES);
	localparam int PTR_W = $clog2(`LANE_FIFO_DEPTH);
	localparam int CNT_W = $clog2(`LANE_FIFO_DEPTH + 1);
	localparam int CRED_W = $clog2(`OUT_CREDITS + 1);

	// credits still available toward the consumer
	logic [CRED_W-1:0] credit_cnt;
	// lane served most recently, the search starts right after it
	logic [LANE_W-1:0] last_lane;
	logic [LANE_W-1:0] grant_lane;
	logic grant_any;

	wire [`NUM_LANES-1:0] fifo_empty;
	wire block_t [`NUM_LANES-1:0] fifo_head;

	for (genvar g = 0; g < `NUM_LANES; g++) begin : g_fifo
		block_t mem [`LANE_FIFO_DEPTH];
		logic [PTR_W-1:0] wr_ptr;
		logic [PTR_W-1:0] rd_ptr;
		logic [CNT_W-1:0] count;
		logic full;
		logic push;
		logic pop;
		logic ovf;

		assign full = (count == CNT_W'(`LANE_FIFO_DEPTH));
		// the deserializer cannot stall so a full FIFO just loses the block
		assign push = in_valid[g] && !full;
		assign pop = out_valid && (grant_lane == LANE_W'(g));
		assign fifo_empty[g] = (count == '0);
		assign fifo_head[g] = mem[rd_ptr];
		assign overflow[g] = ovf;

		always_ff @(posedge clk) begin
			if (push) begin
				mem[wr_ptr] <= in_blk[g];
			end
		end

		always_ff @(posedge clk or posedge arst) begin
			if (arst) begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				count <= '0;
				ovf <= 1'b0;
			end else begin
				if (push) begin
					wr_ptr <= wr_ptr + 1'b1;
				end
				if (pop) begin
					rd_ptr <= rd_ptr + 1'b1;
				end
				case ({push, pop})
					2'b10: count <= count + 1'b1;
					2'b01: count <= count - 1'b1;
					default: count <= count;
				endcase
				// sticky until reset
				if (in_valid[g] && full) begin
					ovf <= 1'b1;
				end
			end
		end
	end

	// round robin search over the lanes, beginning after the one served last
	always_comb begin : pick_lane
		int idx;
		grant_any = 1'b0;
		grant_lane = last_lane;
		for (int k = 1; k <= `NUM_LANES; k++) begin
			idx = (int'(last_lane) + k) % `NUM_LANES;
			if (!grant_any && !fifo_empty[idx]) begin
				grant_any = 1'b1;
				grant_lane = LANE_W'(idx);
			end
		end
	end

	// a word goes out only while a credit is held
	always_comb begin
		out_valid = grant_any && (credit_cnt != '0);
		out_word.lane = grant_lane;
		out_word.blk = fifo_head[grant_lane];
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			credit_cnt <= CRED_W'(`OUT_CREDITS);
			// lane 0 gets the first turn
			last_lane <= LANE_W'(`NUM_LANES - 1);
		end else begin
			case ({out_valid, credit_return})
				2'b10: credit_cnt <= credit_cnt - 1'b1;
				2'b01: credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
			if (out_valid) begin
				last_lane <= grant_lane;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/lane_rx_macros.svh
`ifndef LANE_RX_MACROS_SVH
`define LANE_RX_MACROS_SVH

// the transmitter sends one align block every this many blocks
// and the hunt counter is 8 bits wide to match
`define ALIGN_PERIOD 8'd8

// spaced align blocks needed after the first one before a lane is locked
`define LOCK_GOOD 4

// missing align blocks in a row that make a locked lane fall back to hunting
`define LOCK_BAD 3

// entries in each lane FIFO inside the arbiter
`define LANE_FIFO_DEPTH 4

// credits the arbiter holds toward the consumer after reset
`define OUT_CREDITS 4

// number of receive lanes sharing the output port
`define NUM_LANES 2

`endif

//--- verilog/lane_rx_pkg.sv
`default_nettype none

package lane_rx_pkg;

	// data view of a block with the payload sitting above the kind bit
	typedef struct packed {
		logic [31:0] payload;
		logic        kind;
	} data_blk_t;

	// control view of a block
	// the type byte sits right above the kind bit and the check byte is on top
	typedef struct packed {
		logic [7:0]  check;
		logic [15:0] value;
		logic [7:0]  ctype;
		logic        kind;
	} ctl_blk_t;

	// one 33 bit block as it comes off the line
	// bit 0 goes first and is 1 for data and 0 for control
	typedef union packed {
		data_blk_t data;
		ctl_blk_t  ctl;
	} block_t;

	// word handed to the consumer, tagged with the lane it came from
	typedef struct packed {
		logic   lane;
		block_t blk;
	} rx_word_t;

	// alignment marker, used for lock only and never forwarded
	localparam logic [7:0] CTL_ALIGN = 8'hA5;
	localparam logic [7:0] CTL_IDLE  = 8'h3C;
	localparam logic [7:0] CTL_MARK  = 8'h5A;

	// check byte of a control block is the XOR of its type byte and both value bytes
	function automatic logic [7:0] ctl_check(input logic [7:0] ctype, input logic [15:0] value);
		return ctype ^ value[15:8] ^ value[7:0];
	endfunction

endpackage

`default_nettype wire

//--- verilog/lane_rx_top.sv
`default_nettype none
`timescale 1ns/10ps
`include "lane_rx_macros.svh"

module lane_rx_top import lane_rx_pkg::*; (
	input logic clk,
	input logic arst,
	input logic [`NUM_LANES-1:0][31:0] raw_word,
	input logic [`NUM_LANES-1:0] raw_valid,
	input logic credit_return,
	output rx_word_t out_word,
	output logic out_valid,
	output wire [`NUM_LANES-1:0] locked,
	output wire [`NUM_LANES-1:0] overflow
);

	// blocks from each gearbox and the slip request going back to it
	wire block_t [`NUM_LANES-1:0] gb_blk;
	wire [`NUM_LANES-1:0] gb_valid;
	wire [`NUM_LANES-1:0] slip;

	// blocks that survive lock filtering, one stream per lane
	wire block_t [`NUM_LANES-1:0] fwd_blk;
	wire [`NUM_LANES-1:0] fwd_valid;

	for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
		gearbox_32_33 gearbox_i (
			.clk        (clk),
			.arst       (arst),
			.din        (raw_word[g]),
			.din_valid  (raw_valid[g]),
			.din_slip   (slip[g]),
			.dout       (gb_blk[g]),
			.dout_valid (gb_valid[g])
		);

		// the tracker watches raw_valid to know when its slip was taken
		block_lock lock_i (
			.clk       (clk),
			.arst      (arst),
			.raw_valid (raw_valid[g]),
			.blk       (gb_blk[g]),
			.blk_valid (gb_valid[g]),
			.slip      (slip[g]),
			.locked    (locked[g]),
			.fwd_blk   (fwd_blk[g]),
			.fwd_valid (fwd_valid[g])
		);
	end

	// both lanes share one output port under credit flow control
	lane_arbiter arbiter_i (
		.clk           (clk),
		.arst          (arst),
		.in_blk        (fwd_blk),
		.in_valid      (fwd_valid),
		.credit_return (credit_return),
		.out_word      (out_word),
		.out_valid     (out_valid),
		.overflow      (overflow)
	);

endmodule

`default_nettype wire
